// File: verilog/spi_arb_pkg.sv
`default_nettype none

package spi_arb_pkg;

  localparam int DIV_W = 16; // Width of a serial clock divider field.

  // Register map of the configuration block.
  localparam logic [1:0] CFG_ADDR_DISP_DIV = 2'd0;
  localparam logic [1:0] CFG_ADDR_SD_DIV   = 2'd1;
  localparam logic [1:0] CFG_ADDR_CTRL     = 2'd2;

  // One configuration write word, read either as a divider or as policy bits.
  typedef union packed {
    logic [DIV_W-1:0] div; // Half-period of a serial clock in clk cycles.
    struct packed {
      logic [13:0] rsvd;
      logic        prio_display; // Tie winner when round-robin is off.
      logic        rr_en;        // Round-robin tie-break on.
    } ctrl;
  } cfg_word_u;

endpackage

`default_nettype wire

// File: verilog/spi_cfg_regs.sv
`default_nettype none

module spi_cfg_regs (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           cfg_we,
  input  wire  [1:0]                    cfg_addr,
  input  wire  spi_arb_pkg::cfg_word_u  cfg_wdata,
  output logic [spi_arb_pkg::DIV_W-1:0] disp_div,
  output logic [spi_arb_pkg::DIV_W-1:0] sd_div,
  output logic                          rr_en,
  output logic                          prio_display
);

  import spi_arb_pkg::*;

  logic [DIV_W-1:0] div_clamped;

  // A divider of zero would stall the serial clock, so it becomes one.
  assign div_clamped = (cfg_wdata.div == '0) ? DIV_W'(1) : cfg_wdata.div;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      disp_div     <= DIV_W'(4);
      sd_div       <= DIV_W'(4);
      rr_en        <= 1'b1;
      prio_display <= 1'b0;
    end
    else if (cfg_we)
    begin
      case (cfg_addr)
        CFG_ADDR_DISP_DIV: disp_div <= div_clamped;
        CFG_ADDR_SD_DIV:   sd_div   <= div_clamped;
        CFG_ADDR_CTRL:
        begin
          rr_en        <= cfg_wdata.ctrl.rr_en;
          prio_display <= cfg_wdata.ctrl.prio_display;
        end
        default: ; // Address 3 is unmapped.
      endcase
    end
  end

  // Both masters rely on a divider that is never zero, from reset onwards.
  a_div_nonzero: assert property (@(posedge clk) disable iff (rst)
    (disp_div != '0) && (sd_div != '0));

endmodule

`default_nettype wire

// File: verilog/spi_arb.sv
`default_nettype none

module spi_arb #(
  parameter int SETTLE_EDGES = 4
) (
  input  wire  clk,
  input  wire  rst,
  input  wire  rr_en,
  input  wire  prio_display,
  input  wire  display_req,
  input  wire  display_done,
  input  wire  display_spi_sck,
  input  wire  display_spi_cs,
  input  wire  display_spi_dc,
  input  wire  display_spi_data,
  input  wire  sdcard_req,
  input  wire  sdcard_done,
  input  wire  sdcard_spi_sck,
  input  wire  sdcard_spi_cs,
  input  wire  sdcard_spi_dc,
  input  wire  sdcard_spi_data,
  output logic sck,
  output logic display_cs,
  output logic sdcard_cs,
  output logic rs_dc,
  output logic mosi,
  output logic display_ack,
  output logic sdcard_ack
);

  localparam logic [1:0] ST_IDLE      = 2'd0;
  localparam logic [1:0] ST_REQUESTED = 2'd1;
  localparam logic [1:0] ST_GRANTED   = 2'd2;
  localparam int         CNT_W        = $clog2(SETTLE_EDGES + 1);

  logic [1:0]       state;
  logic             sel_disp;
  logic             tie_bit;
  logic             sck_q;
  logic             switched;
  logic [CNT_W-1:0] settle_cnt;
  logic             settled;
  logic             sck_fall;
  logic             want_disp;
  logic             same_client;

  // ########################################
  // Output multiplexer
  always_comb
  begin
    if (sel_disp)
    begin
      sck        = display_spi_sck;
      display_cs = display_spi_cs;
      sdcard_cs  = 1'b1;
      rs_dc      = display_spi_dc;
      mosi       = display_spi_data;
    end
    else
    begin
      sck        = sdcard_spi_sck;
      display_cs = 1'b1;
      sdcard_cs  = sdcard_spi_cs;
      rs_dc      = sdcard_spi_dc;
      mosi       = sdcard_spi_data;
    end
  end

  // The cycle after a switch compares two different clocks and is ignored.
  assign sck_fall    = sck_q && !sck && !switched;
  assign settled     = (settle_cnt >= CNT_W'(SETTLE_EDGES));
  assign same_client = (want_disp == sel_disp);

  always_comb
  begin
    if (display_req && sdcard_req)
      want_disp = rr_en ? tie_bit : prio_display;
    else
      want_disp = display_req;
  end

  // ########################################
  // Arbitration FSM
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= ST_IDLE;
      sel_disp    <= 1'b0;
      tie_bit     <= 1'b0;
      sck_q       <= 1'b0;
      switched    <= 1'b0;
      settle_cnt  <= '0;
      display_ack <= 1'b0;
      sdcard_ack  <= 1'b0;
    end
    else
    begin
      sck_q       <= sck;
      switched    <= 1'b0;
      display_ack <= 1'b0;
      sdcard_ack  <= 1'b0;
      if (sck_fall && !settled)
        settle_cnt <= settle_cnt + 1'b1; // Saturates at the settle count.
      case (state)
        ST_IDLE:
        begin
          if (display_req || sdcard_req)
          begin
            if (display_req && sdcard_req && rr_en)
              tie_bit <= ~tie_bit; // Loser wins the next tie.
            if (same_client && settled)
            begin
              state       <= ST_GRANTED;
              display_ack <= want_disp;
              sdcard_ack  <= !want_disp;
            end
            else
            begin
              state    <= ST_REQUESTED;
              sel_disp <= want_disp;
              if (!same_client)
              begin
                settle_cnt <= '0;
                switched   <= 1'b1;
              end
            end
          end
        end
        ST_REQUESTED:
        begin
          if (settled)
          begin
            state       <= ST_GRANTED;
            display_ack <= sel_disp;
            sdcard_ack  <= !sel_disp;
          end
        end
        ST_GRANTED:
        begin
          if (sel_disp ? display_done : sdcard_done)
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // An acknowledge only reaches a client that still requests, and never both.
  a_ack_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(display_ack && sdcard_ack) && (!display_ack || display_req) &&
    (!sdcard_ack || sdcard_req));

  // A master may only finish a transfer that the arbiter granted to it.
  a_done_granted: assert property (@(posedge clk) disable iff (rst)
    (display_done || sdcard_done) |-> (state == ST_GRANTED) &&
    (display_done ? sel_disp : !sel_disp));

  // Only the granted master may pull its own chip select low.
  a_cs_exclusive: assert property (@(posedge clk) disable iff (rst)
    display_spi_cs || sdcard_spi_cs);

endmodule

`default_nettype wire

// File: verilog/display_spi_master.sv
`default_nettype none

module display_spi_master (
  input  wire                           clk,
  input  wire                           rst,
  input  wire  [spi_arb_pkg::DIV_W-1:0] div,
  input  wire                           start,
  input  wire  [7:0]                    tx_byte,
  input  wire                           dc,
  input  wire                           ack,
  output logic                          req,
  output logic                          done,
  output logic                          spi_sck,
  output logic                          spi_cs,
  output logic                          spi_dc,
  output logic                          spi_data,
  output logic                          busy
);

  import spi_arb_pkg::*;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_REQ   = 2'd1;
  localparam logic [1:0] ST_ARMED = 2'd2;
  localparam logic [1:0] ST_SHIFT = 2'd3;

  logic [1:0]       state;
  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic             sck_fall;
  logic [7:0]       shift_r;
  logic [2:0]       bit_cnt;

  assign tick     = (div_cnt >= div - 1'b1);
  assign sck_fall = tick && spi_sck;
  assign spi_data = shift_r[7];
  assign req      = (state != ST_IDLE);
  assign busy     = req;

  // ########################################
  // Serial clock, running all the time
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt <= '0;
      spi_sck <= 1'b0;
    end
    else if (tick)
    begin
      div_cnt <= '0;
      spi_sck <= ~spi_sck;
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= ST_IDLE;
      done    <= 1'b0;
      spi_cs  <= 1'b1;
      bit_cnt <= '0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        ST_IDLE: if (start) state <= ST_REQ;
        ST_REQ:  if (ack) state <= ST_ARMED;
        ST_ARMED:
        begin
          if (sck_fall)
          begin
            state   <= ST_SHIFT; // MSB is already on the data line.
            spi_cs  <= 1'b0;
            bit_cnt <= '0;
          end
        end
        default:
        begin
          if (sck_fall)
          begin
            if (bit_cnt == 3'd7)
            begin
              state  <= ST_IDLE;
              spi_cs <= 1'b1;
              done   <= 1'b1;
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && start)
    begin
      shift_r <= tx_byte;
      spi_dc  <= dc; // Held for the whole transfer.
    end
    else if (state == ST_SHIFT && sck_fall && bit_cnt != 3'd7)
      shift_r <= {shift_r[6:0], 1'b0};
  end

endmodule

`default_nettype wire

// File: verilog/sdcard_spi_master.sv
`default_nettype none

module sdcard_spi_master (
  input  wire                           clk,
  input  wire                           rst,
  input  wire  [spi_arb_pkg::DIV_W-1:0] div,
  input  wire                           start,
  input  wire  [7:0]                    tx_byte,
  input  wire                           ack,
  input  wire                           miso,
  output logic                          req,
  output logic                          done,
  output logic                          spi_sck,
  output logic                          spi_cs,
  output logic                          spi_data,
  output logic [7:0]                    rx_byte,
  output logic                          rx_valid
);

  import spi_arb_pkg::*;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_REQ   = 2'd1;
  localparam logic [1:0] ST_ARMED = 2'd2;
  localparam logic [1:0] ST_SHIFT = 2'd3;

  logic [1:0]       state;
  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic             sck_fall;
  logic             sck_rise;
  logic             last_fall;
  logic [7:0]       shift_r;
  logic [7:0]       rx_shift;
  logic [2:0]       bit_cnt;

  assign tick      = (div_cnt >= div - 1'b1);
  assign sck_fall  = tick && spi_sck;
  assign sck_rise  = tick && !spi_sck;
  assign last_fall = (state == ST_SHIFT) && sck_fall && (bit_cnt == 3'd7);
  assign spi_data  = shift_r[7];
  assign req       = (state != ST_IDLE);

  // ########################################
  // Serial clock, running all the time
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt <= '0;
      spi_sck <= 1'b0;
    end
    else if (tick)
    begin
      div_cnt <= '0;
      spi_sck <= ~spi_sck;
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      done     <= 1'b0;
      rx_valid <= 1'b0;
      spi_cs   <= 1'b1;
      bit_cnt  <= '0;
    end
    else
    begin
      done     <= last_fall;
      rx_valid <= last_fall;
      case (state)
        ST_IDLE: if (start) state <= ST_REQ;
        ST_REQ:  if (ack) state <= ST_ARMED;
        ST_ARMED:
        begin
          if (sck_fall)
          begin
            state   <= ST_SHIFT;
            spi_cs  <= 1'b0;
            bit_cnt <= '0;
          end
        end
        default:
        begin
          if (last_fall)
          begin
            state  <= ST_IDLE;
            spi_cs <= 1'b1;
          end
          else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && start)
      shift_r <= tx_byte;
    else if (state == ST_SHIFT && sck_fall && !last_fall)
      shift_r <= {shift_r[6:0], 1'b0};
    if (state == ST_SHIFT && sck_rise)
      rx_shift <= {rx_shift[6:0], miso}; // Slave drives miso on falling edges.
    if (last_fall)
      rx_byte <= rx_shift;
  end

endmodule

`default_nettype wire

// File: verilog/spi_bus_top.sv
`default_nettype none

module spi_bus_top #(
  parameter int SETTLE_EDGES = 4
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          cfg_we,
  input  wire  [1:0]                   cfg_addr,
  input  wire  spi_arb_pkg::cfg_word_u cfg_wdata,
  input  wire                          disp_start,
  input  wire  [7:0]                   disp_byte,
  input  wire                          disp_dc,
  input  wire                          sd_start,
  input  wire  [7:0]                   sd_byte,
  input  wire                          miso,
  output logic                         sck,
  output logic                         display_cs,
  output logic                         sdcard_cs,
  output logic                         rs_dc,
  output logic                         mosi,
  output logic                         disp_busy,
  output logic [7:0]                   sd_rx_byte,
  output logic                         sd_rx_valid
);

  import spi_arb_pkg::*;

  logic [DIV_W-1:0] disp_div;
  logic [DIV_W-1:0] sd_div;
  logic             rr_en;
  logic             prio_display;
  logic             disp_req;
  logic             disp_done;
  logic             disp_ack;
  logic             disp_sck;
  logic             disp_cs;
  logic             disp_rs;
  logic             disp_data;
  logic             sd_req;
  logic             sd_done;
  logic             sd_ack;
  logic             sd_sck;
  logic             sd_cs;
  logic             sd_data;

  spi_cfg_regs i_cfg (
    .clk          (clk),
    .rst          (rst),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .disp_div     (disp_div),
    .sd_div       (sd_div),
    .rr_en        (rr_en),
    .prio_display (prio_display)
  );

  display_spi_master i_disp (
    .clk      (clk),
    .rst      (rst),
    .div      (disp_div),
    .start    (disp_start),
    .tx_byte  (disp_byte),
    .dc       (disp_dc),
    .ack      (disp_ack),
    .req      (disp_req),
    .done     (disp_done),
    .spi_sck  (disp_sck),
    .spi_cs   (disp_cs),
    .spi_dc   (disp_rs),
    .spi_data (disp_data),
    .busy     (disp_busy)
  );

  sdcard_spi_master i_sd (
    .clk      (clk),
    .rst      (rst),
    .div      (sd_div),
    .start    (sd_start),
    .tx_byte  (sd_byte),
    .ack      (sd_ack),
    .miso     (miso),
    .req      (sd_req),
    .done     (sd_done),
    .spi_sck  (sd_sck),
    .spi_cs   (sd_cs),
    .spi_data (sd_data),
    .rx_byte  (sd_rx_byte),
    .rx_valid (sd_rx_valid)
  );

  spi_arb #(
    .SETTLE_EDGES (SETTLE_EDGES)
  ) i_arb (
    .clk              (clk),
    .rst              (rst),
    .rr_en            (rr_en),
    .prio_display     (prio_display),
    .display_req      (disp_req),
    .display_done     (disp_done),
    .display_spi_sck  (disp_sck),
    .display_spi_cs   (disp_cs),
    .display_spi_dc   (disp_rs),
    .display_spi_data (disp_data),
    .sdcard_req       (sd_req),
    .sdcard_done      (sd_done),
    .sdcard_spi_sck   (sd_sck),
    .sdcard_spi_cs    (sd_cs),
    .sdcard_spi_dc    (1'b1), // The SD card keeps the shared select line high.
    .sdcard_spi_data  (sd_data),
    .sck              (sck),
    .display_cs       (display_cs),
    .sdcard_cs        (sdcard_cs),
    .rs_dc            (rs_dc),
    .mosi             (mosi),
    .display_ack      (disp_ack),
    .sdcard_ack       (sd_ack)
  );

endmodule

`default_nettype wire

// File: bench/tb_spi_bus_top.sv
`default_nettype none

module tb_spi_bus_top;
  timeunit 1ns;
  timeprecision 1ps;

  import spi_arb_pkg::*;

  localparam int CLK_HALF   = 20;
  localparam int CLK_PERIOD = 2 * CLK_HALF;
  localparam int RST_CYCLES = 8;

  logic        clk;
  logic        rst;
  logic        cfg_we;
  logic [1:0]  cfg_addr;
  logic [15:0] cfg_wdata;
  logic        disp_start;
  logic [7:0]  disp_byte;
  logic        disp_dc;
  logic        sd_start;
  logic [7:0]  sd_byte;
  logic        miso;
  logic        sck;
  logic        display_cs;
  logic        sdcard_cs;
  logic        rs_dc;
  logic        mosi;
  logic        disp_busy;
  logic [7:0]  sd_rx_byte;
  logic        sd_rx_valid;

  int         errors;
  bit         timed_out;
  int         disp_div_m;
  int         sd_div_m;
  logic       exp_dc;
  logic [7:0] miso_q;
  int         cap_bits;
  logic [7:0] cap_byte;
  realtime    t_first;
  realtime    t_last;
  bit         rec_client[$]; // One entry per chip-select window, 1 for the display.
  logic [7:0] rec_byte[$];
  int         rec_period[$];
  bit         rx_seen;
  logic [7:0] rx_got;

  assign miso = miso_q[7];

  spi_bus_top #(
    .SETTLE_EDGES (4)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .disp_start  (disp_start),
    .disp_byte   (disp_byte),
    .disp_dc     (disp_dc),
    .sd_start    (sd_start),
    .sd_byte     (sd_byte),
    .miso        (miso),
    .sck         (sck),
    .display_cs  (display_cs),
    .sdcard_cs   (sdcard_cs),
    .rs_dc       (rs_dc),
    .mosi        (mosi),
    .disp_busy   (disp_busy),
    .sd_rx_byte  (sd_rx_byte),
    .sd_rx_valid (sd_rx_valid)
  );

  always #CLK_HALF clk = ~clk;

  // ########################################
  // SPI slave model
  task automatic close_window(input bit is_disp);
    assert (cap_bits == 8)
    else
    begin
      $display("Mismatch window bit count: got %h, expected %h", cap_bits, 8);
      errors++;
    end
    rec_client.push_back(is_disp);
    rec_byte.push_back(cap_byte);
    rec_period.push_back(int'((t_last - t_first) / 7.0));
    cap_bits = 0;
  endtask

  always @(negedge display_cs or negedge sdcard_cs)
  begin
    cap_bits = 0;
    cap_byte = '0;
  end

  always @(posedge display_cs)
  begin
    if (cap_bits != 0)
      close_window(1'b1);
  end

  always @(posedge sdcard_cs)
  begin
    if (cap_bits != 0)
      close_window(1'b0);
  end

  always @(posedge sck)
  begin
    if (!rst && (display_cs === 1'b0 || sdcard_cs === 1'b0))
    begin
      assert (cap_bits < 8)
      else
      begin
        $display("Serial clock kept running after eight bits in one chip-select window");
        errors++;
      end
      if (cap_bits == 0)
        t_first = $realtime;
      t_last   = $realtime;
      cap_byte = {cap_byte[6:0], mosi};
      cap_bits++;
      if (display_cs === 1'b0)
      begin
        assert (rs_dc === exp_dc)
        else
        begin
          $display("Mismatch rs_dc: got %h, expected %h", rs_dc, exp_dc);
          errors++;
        end
      end
      else
      begin
        assert (rs_dc === 1'b1)
        else
        begin
          $display("Mismatch rs_dc: got %h, expected %h", rs_dc, 1'b1);
          errors++;
        end
      end
    end
  end

  // The reply moves on one bit at every falling edge after the first rising edge.
  always @(negedge sck)
  begin
    #2;
    if (sdcard_cs === 1'b0 && cap_bits != 0)
      miso_q = {miso_q[6:0], 1'b0};
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      assert (!(display_cs === 1'b0 && sdcard_cs === 1'b0))
      else
      begin
        $display("Both chip selects are low at %0t", $realtime);
        errors++;
      end
      if (display_cs === 1'b0)
      begin
        assert (disp_busy === 1'b1)
        else
        begin
          $display("Mismatch disp_busy: got %h, expected %h", disp_busy, 1'b1);
          errors++;
        end
      end
      if (sd_rx_valid)
      begin
        rx_seen = 1'b1;
        rx_got  = sd_rx_byte;
      end
    end
  end

  // ########################################
  // Stimulus tasks
  task automatic write_cfg(input logic [1:0] addr, input logic [15:0] data);
    @(posedge clk);
    #2;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #2;
    cfg_we = 1'b0;
    if (addr == CFG_ADDR_DISP_DIV)
      disp_div_m = (data == 16'd0) ? 1 : int'(data); // A zero divider is stored as one.
    else if (addr == CFG_ADDR_SD_DIV)
      sd_div_m = (data == 16'd0) ? 1 : int'(data);
  endtask

  task automatic wait_done(input int n_exp, input bit need_rx, input int line_no);
    int cycles;
    int limit;
    cycles = 0;
    limit  = 200 + 64 * (disp_div_m + sd_div_m);
    while ((rec_client.size() < n_exp || disp_busy || (need_rx && !rx_seen)) &&
           cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= limit)
    begin
      $display("Timeout: the transfer of test data line %0d did not finish", line_no);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_transfer(input string op, input logic [7:0] d_byte, input logic d_dc,
                              input logic [7:0] s_byte, input logic [7:0] reply,
                              input bit disp_first, input int line_no);
    bit         use_disp;
    bit         use_sd;
    int         n_exp;
    bit         exp_client;
    logic [7:0] exp_byte;
    int         exp_period;
    use_disp = (op == "d") || (op == "b");
    use_sd   = (op == "s") || (op == "b");
    n_exp    = (use_disp && use_sd) ? 2 : 1;
    rec_client.delete();
    rec_byte.delete();
    rec_period.delete();
    rx_seen = 1'b0;
    miso_q  = reply;
    exp_dc  = d_dc;
    @(posedge clk);
    #2;
    disp_byte  = d_byte;
    disp_dc    = d_dc;
    sd_byte    = s_byte;
    disp_start = use_disp;
    sd_start   = use_sd;
    @(posedge clk);
    #2;
    disp_start = 1'b0;
    sd_start   = 1'b0;
    wait_done(n_exp, use_sd, line_no);
    if (!timed_out)
    begin
      assert (rec_client.size() == n_exp)
      else
      begin
        $display("Mismatch window count: got %h, expected %h", rec_client.size(), n_exp);
        errors++;
      end
      for (int i = 0; i < rec_client.size() && i < n_exp; i++)
      begin
        if (use_disp && use_sd)
          exp_client = (i == 0) ? disp_first : !disp_first;
        else
          exp_client = use_disp;
        exp_byte   = exp_client ? d_byte : s_byte;
        exp_period = 2 * CLK_PERIOD * (exp_client ? disp_div_m : sd_div_m);
        assert (rec_client[i] == exp_client)
        else
        begin
          $display("Mismatch chip select order (1 = display_cs): got %h, expected %h",
                   rec_client[i], exp_client);
          errors++;
        end
        assert (rec_byte[i] === exp_byte)
        else
        begin
          $display("Mismatch mosi byte: got %h, expected %h", rec_byte[i], exp_byte);
          errors++;
        end
        assert (rec_period[i] == exp_period)
        else
        begin
          $display("Mismatch sck period in ns: got %h, expected %h", rec_period[i], exp_period);
          errors++;
        end
      end
      if (use_sd)
      begin
        assert (rx_got === reply)
        else
        begin
          $display("Mismatch sd_rx_byte: got %h, expected %h", rx_got, reply);
          errors++;
        end
      end
    end
  endtask

  // ########################################
  // Main sequence
  initial
  begin
    int          fd;
    int          n;
    int          line_no;
    int          gap;
    string       line;
    string       op;
    logic [15:0] f_addr;
    logic [15:0] f_data;
    logic [7:0]  f_dbyte;
    logic        f_dc;
    logic [7:0]  f_sbyte;
    logic [7:0]  f_reply;
    logic        f_first;
    clk        = 1'b0;
    rst        = 1'b1;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    disp_start = 1'b0;
    disp_byte  = '0;
    disp_dc    = 1'b0;
    sd_start   = 1'b0;
    sd_byte    = '0;
    miso_q     = '0;
    errors     = 0;
    timed_out  = 1'b0;
    disp_div_m = 4; // Reset value of both divider registers.
    sd_div_m   = 4;
    exp_dc     = 1'b0;
    line_no    = 0;
    void'($urandom(32'h5999_2ec0));
    fd = $fopen("bench/spi_bus_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test data file");
      errors++;
    end
    else
    begin
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      rst = 1'b0;
      while (!$feof(fd) && !timed_out)
      begin
        line = "";
        n = $fgets(line, fd);
        line_no++;
        if (n == 0 || line.len() < 2 || line[0] == "#")
          continue;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h", op, f_addr, f_data, f_dbyte, f_dc,
                    f_sbyte, f_reply, f_first);
        if (n != 8)
        begin
          $display("Test data line %0d has %0d fields instead of 8", line_no, n);
          errors++;
        end
        else if (op == "w")
          write_cfg(f_addr[1:0], f_data);
        else if (op == "d" || op == "s" || op == "b")
          run_transfer(op, f_dbyte, f_dc, f_sbyte, f_reply, f_first, line_no);
        else
        begin
          $display("Unknown operation on test data line %0d", line_no);
          errors++;
        end
        gap = $urandom_range(8, 1);
        repeat (gap) @(posedge clk);
      end
      $fclose(fd);
    end
    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/spi_bus_testdata.txt
# op addr data dbyte dc sbyte reply first   (all fields hex)
# op w = config write, d = display, s = SD card, b = both started together; first 1 = display first
d 0 0000 a5 1 00 00 1
s 0 0000 00 0 3c c3 0
b 0 0000 96 1 69 5a 0
b 0 0000 12 0 34 56 1
b 0 0000 f0 1 0f e1 0
w 2 0002 00 0 00 00 0
b 0 0000 c3 0 3c 99 1
b 0 0000 77 1 88 44 1
w 2 0000 00 0 00 00 0
b 0 0000 01 1 80 7f 0
w 0 0006 00 0 00 00 0
w 1 0003 00 0 00 00 0
d 0 0000 5a 0 00 00 1
s 0 0000 00 0 81 7e 0
b 0 0000 e7 1 18 b6 0
w 0 0000 00 0 00 00 0
w 1 0002 00 0 00 00 0
w 2 0001 00 0 00 00 0
b 0 0000 2d 0 d2 3b 1
b 0 0000 4b 1 b4 c8 0
d 0 0000 00 1 00 00 1
s 0 0000 00 0 ff 00 0

// File: filelist.f
verilog/spi_arb_pkg.sv
verilog/spi_cfg_regs.sv
verilog/spi_arb.sv
verilog/display_spi_master.sv
verilog/sdcard_spi_master.sv
verilog/spi_bus_top.sv
bench/tb_spi_bus_top.sv

// File: Makefile
# Verilator build and run for the shared SPI bus testbench.

VERILATOR ?= verilator
TOP       ?= tb_spi_bus_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the log holds the pass line.
run: compile
	./$(BINARY) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
